// File: tb/cell_search_patterns.txt
# name n_id_2 n_id_1 amplitude noise exp_pss_count exp_n_id_2 exp_n_id_1 exp_n_id
# Amplitude is the chip level on the real rail, noise 1 adds up to amplitude/4 per rail.
clean_n2_0_n1_0      0  0 3600 0 1 0  0  0
clean_n2_1_n1_7      1  7 3600 0 1 1  7 22
clean_n2_2_n1_15     2 15 3600 0 1 2 15 47
silence_only         0  0    0 0 0 0  0  0
clean_n2_1_n1_15     1 15 3600 0 1 1 15 46
clean_n2_2_n1_0      2  0 3600 0 1 2  0  2
clean_n2_0_n1_7      0  7 3600 0 1 0  7 21
below_threshold      2  9 2000 0 0 0  0  0
noisy_n2_0_n1_15     0 15 3600 1 1 0 15 45
noisy_n2_1_n1_0      1  0 3600 1 1 1  0  1
noisy_n2_2_n1_7      2  7 3600 1 1 2  7 23
noisy_below          0  3 2000 1 0 0  0  0
back_to_back_first   1 11 3600 0 1 1 11 34
back_to_back_second  2  4 3600 0 1 2  4 14

// File: filelist.f
+incdir+hdl
hdl/sample_pkg.sv
hdl/sync_pkg.sv
hdl/cic_decimator.sv
hdl/pss_correlator.sv
hdl/sss_detector.sv
hdl/cell_search_top.sv
tb/cell_search_clkgen.sv
tb/cell_search_tb.sv

// File: Bender.yml
package:
  name: cell_search

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sample_pkg.sv
      - hdl/sync_pkg.sv
      - hdl/cic_decimator.sv
      - hdl/pss_correlator.sv
      - hdl/sss_detector.sv
      - hdl/cell_search_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/cell_search_clkgen.sv
      - tb/cell_search_tb.sv

// File: tb/cell_search_tb.sv
`timescale 1ns/1ps
`include "cell_search_consts.svh"

module cell_search_tb
    import sample_pkg::*;
    import sync_pkg::*;
();

    localparam int MAX_TESTS   = 64;
    localparam int CHIP_IN     = 2 * `CIC_R;   // Input samples per chip.
    localparam int PSS_START   = 32;
    localparam int SSS_START   = PSS_START + `PSS_LEN * CHIP_IN + `SSS_GAP * `CIC_R;
    localparam int BURST_LEN   = SSS_START + `SSS_LEN * CHIP_IN + 96;
    localparam int WAIT_GROUPS = 16;

    logic       clk;
    logic       reset_n;
    iq_sample_t s_in_data;
    logic       s_in_valid;
    logic       pss_valid;
    n_id_2_t    n_id_2;
    logic       sss_valid;
    n_id_1_t    n_id_1;
    n_id_t      n_id;

    // Pattern columns are N_id_2, N_id_1, amplitude, noise, pss count and the three identities.
    string       test_name [MAX_TESTS];
    int          pat [MAX_TESTS][8];
    int          n_tests;
    logic        tests_loaded;
    string       cur_name;
    integer      seed;
    int          error_count;
    int          check_count;
    int          pss_cnt;
    int          sss_cnt;
    int          got_n2;
    int          got_n1;
    int          got_nid;
    logic [31:0] burst_q [$];

    cell_search_clkgen #(.PERIOD_NS(8.0)) clkgen_i (.clk_o(clk));

    cell_search_top UUT (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .s_in_data_i (s_in_data),
        .s_in_valid_i(s_in_valid),
        .pss_valid_o (pss_valid),
        .n_id_2_o    (n_id_2),
        .sss_valid_o (sss_valid),
        .n_id_1_o    (n_id_1),
        .n_id_o      (n_id)
    );

    function automatic logic [`SSS_LEN-1:0] rotate_word(input logic [`SSS_LEN-1:0] w, input int n);
        return (w << n) | (w >> (`SSS_LEN - n));
    endfunction

    function automatic logic [`PSS_LEN-1:0] pss_word(input int n2);
        case (n2)
            0:       return `PSS_SEQ_0;
            1:       return `PSS_SEQ_1;
            default: return `PSS_SEQ_2;
        endcase
    endfunction

    function automatic logic [`SSS_LEN-1:0] sss_candidate(input int n1, input int n2);
        logic [`SSS_LEN-1:0] scramble;
        case (n2)
            0:       scramble = `SSS_SEED_0;
            1:       scramble = `SSS_SEED_1;
            default: scramble = `SSS_SEED_2;
        endcase
        return rotate_word(`SSS_BASE, n1) ^ scramble;
    endfunction

    // Silence, PSS chips, a silent gap, SSS chips and a silent tail, all on the real rail.
    task automatic build_burst(input int idx);
        logic [`PSS_LEN-1:0] pss_w;
        logic [`SSS_LEN-1:0] sss_w;
        int                  re;
        int                  im;
        int                  lim;
        burst_q.delete();
        pss_w = pss_word(pat[idx][0]);
        sss_w = sss_candidate(pat[idx][1], pat[idx][0]);
        lim   = pat[idx][2] / 4 + 1;
        for (int i = 0; i < BURST_LEN; i++) begin
            re = 0;
            im = 0;
            if (i >= PSS_START && i < PSS_START + `PSS_LEN * CHIP_IN) begin
                re = pss_w[(i - PSS_START) / CHIP_IN] ? pat[idx][2] : -pat[idx][2];
            end else if (i >= SSS_START && i < SSS_START + `SSS_LEN * CHIP_IN) begin
                re = sss_w[(i - SSS_START) / CHIP_IN] ? pat[idx][2] : -pat[idx][2];
            end
            if (pat[idx][3] != 0) begin
                re = re + $random(seed) % lim;
                im = im + $random(seed) % lim;
            end
            burst_q.push_back({im[15:0], re[15:0]});
        end
    endtask

    task automatic drive_sample(input logic [31:0] word);
        @(posedge clk);
        s_in_data  <= word;
        s_in_valid <= 1'b1;
    endtask

    task automatic compare_field(input string what, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            $display("Error: test %s, %s expected %0d, actual %0d", cur_name, what, expected,
                     actual);
            error_count++;
        end
    endtask

    task automatic check_results(input int idx);
        check_count++;
        if (pss_cnt != pat[idx][4]) begin
            $display("Test %s gave %0d pss_valid_o pulses where %0d were expected", cur_name,
                     pss_cnt, pat[idx][4]);
            error_count++;
        end
        check_count++;
        if (sss_cnt != pat[idx][4]) begin
            $display("Test %s gave %0d sss_valid_o pulses where %0d were expected", cur_name,
                     sss_cnt, pat[idx][4]);
            error_count++;
        end
        if (pat[idx][4] != 0 && pss_cnt > 0) begin
            compare_field("n_id_2_o", pat[idx][5], got_n2);
        end
        if (pat[idx][4] != 0 && sss_cnt > 0) begin
            compare_field("n_id_1_o", pat[idx][6], got_n1);
            compare_field("n_id_o", pat[idx][7], got_nid);
            compare_field("n_id_o from 3*N_id_1+N_id_2", 3 * pat[idx][6] + pat[idx][5], got_nid);
        end
    endtask

    task automatic read_patterns();
        int    fd;
        int    fields;
        string line;
        string name;
        int    v [8];
        fd = $fopen("tb/cell_search_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file tb/cell_search_patterns.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d", name, v[0], v[1],
                                     v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (fields == 9) begin
                        test_name[n_tests] = name;
                        for (int c = 0; c < 8; c++) begin
                            pat[n_tests][c] = v[c];
                        end
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Clearing the counters at a rising edge cannot race with the monitor on the falling edge.
    task automatic run_test(input int idx);
        int waited;
        cur_name = test_name[idx];
        pss_cnt  = 0;
        sss_cnt  = 0;
        build_burst(idx);
        foreach (burst_q[i]) begin
            drive_sample(burst_q[i]);
        end
        waited = 0;
        while (pat[idx][4] != 0 && sss_cnt == 0 && waited < WAIT_GROUPS) begin
            repeat (CHIP_IN) drive_sample('0);   // Whole chips keep the decimation phase.
            waited++;
        end
        check_results(idx);
    endtask

    always @(negedge clk) begin
        if (reset_n) begin
            if (pss_valid) begin
                pss_cnt++;
                got_n2 = n_id_2;
            end
            if (sss_valid) begin
                if (pss_cnt == 0) begin
                    $display("Test %s: sss_valid_o came before any pss_valid_o", cur_name);
                    error_count++;
                end
                sss_cnt++;
                got_n1  = n_id_1;
                got_nid = n_id;
            end
        end
    end

    initial begin
        reset_n      = 1'b0;
        s_in_data    = '0;
        s_in_valid   = 1'b0;
        seed         = 4;
        error_count  = 0;
        check_count  = 0;
        n_tests      = 0;
        tests_loaded = 1'b0;
        pss_cnt      = 0;
        sss_cnt      = 0;
        cur_name     = "reset";
        read_patterns();
        tests_loaded = 1'b1;
        if (n_tests == 0) begin
            $display("No tests were read from the pattern file");
            error_count++;
        end
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Twice the time that the bursts need, plus room for reset.
    initial begin
        wait (tests_loaded);
        #(n_tests * BURST_LEN * 16 + 2000);
        $display("Watchdog expired before all tests finished");
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb/cell_search_clkgen.sv
`timescale 1ns/1ps

module cell_search_clkgen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // Half a period per level.
        end
    end

endmodule

// File: hdl/cell_search_top.sv
`timescale 1ns/1ps
`include "cell_search_consts.svh"

module cell_search_top import sample_pkg::*; import sync_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t s_in_data_i,
    input  logic       s_in_valid_i,
    output logic       pss_valid_o,
    output n_id_2_t    n_id_2_o,
    output logic       sss_valid_o,
    output n_id_1_t    n_id_1_o,
    output n_id_t      n_id_o
);

    rail_t      dec_re;
    rail_t      dec_im;
    logic       dec_valid;
    iq_sample_t dec_sample;

    // Both rails decimate in lockstep, so the real instance alone marks valid samples.
    cic_decimator #(
        .DW(`IQ_DW)
    ) cic_re (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .data_i  (s_in_data_i.re),
        .valid_i (s_in_valid_i),
        .data_o  (dec_re),
        .valid_o (dec_valid)
    );

    cic_decimator #(
        .DW(`IQ_DW)
    ) cic_im (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .data_i  (s_in_data_i.im),
        .valid_i (s_in_valid_i),
        .data_o  (dec_im),
        .valid_o ()
    );

    assign dec_sample = {dec_im, dec_re};

    pss_correlator pss_correlator_i (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .sample_i(dec_sample),
        .valid_i (dec_valid),
        .n_id_2_o(n_id_2_o),
        .peak_o  (pss_valid_o)
    );

    // The SSS follows the PSS in time, so the detector reads the same decimated stream.
    sss_detector sss_detector_i (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .sample_i(dec_sample),
        .valid_i (dec_valid),
        .n_id_2_i(n_id_2_o),
        .peak_i  (pss_valid_o),
        .n_id_1_o(n_id_1_o),
        .n_id_o  (n_id_o),
        .valid_o (sss_valid_o)
    );

endmodule

// File: hdl/sss_detector.sv
`timescale 1ns/1ps
`include "cell_search_consts.svh"

module sss_detector import sample_pkg::*; import sync_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  logic       valid_i,
    input  n_id_2_t    n_id_2_i,
    input  logic       peak_i,
    output n_id_1_t    n_id_1_o,
    output n_id_t      n_id_o,
    output logic       valid_o
);

    typedef enum logic [1:0] {IDLE, GAP, COLLECT, SEARCH} state_t;

    localparam int GAP_W   = $clog2(`SSS_GAP + 1);
    localparam int CNT_W   = $clog2(2 * `SSS_LEN);
    localparam int SCORE_W = $clog2(`SSS_LEN + 1);

    state_t              state_q;
    logic [GAP_W-1:0]    gap_cnt_q;
    logic [CNT_W-1:0]    smp_cnt_q;
    logic [`SSS_LEN-1:0] chips_q;   // Chip i lands in bit i.
    n_id_2_t             nid2_q;
    n_id_1_t             cand_q;
    n_id_1_t             best_idx_q;
    logic [SCORE_W-1:0]  best_score_q;
    logic [`SSS_LEN-1:0] seed;
    logic [`SSS_LEN-1:0] cand_word;
    logic [SCORE_W-1:0]  score;
    n_id_1_t             final_idx;

    function automatic logic [`SSS_LEN-1:0] rotate_left(input logic [`SSS_LEN-1:0] w,
                                                        input n_id_1_t n);
        logic [2*`SSS_LEN-1:0] twice;
        twice = {w, w} << n;
        return twice[2*`SSS_LEN-1 -: `SSS_LEN];
    endfunction

    function automatic logic [SCORE_W-1:0] ones(input logic [`SSS_LEN-1:0] w);
        logic [SCORE_W-1:0] n;
        n = '0;
        for (int i = 0; i < `SSS_LEN; i++) begin
            n = n + SCORE_W'(w[i]);
        end
        return n;
    endfunction

    always_comb begin
        case (nid2_q)
            2'd0:    seed = `SSS_SEED_0;
            2'd1:    seed = `SSS_SEED_1;
            default: seed = `SSS_SEED_2;
        endcase
        cand_word = rotate_left(`SSS_BASE, cand_q) ^ seed;
        score     = ones(~(chips_q ^ cand_word));   // Count of agreeing chips.
        final_idx = (score > best_score_q) ? cand_q : best_idx_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= IDLE;
            gap_cnt_q    <= '0;
            smp_cnt_q    <= '0;
            nid2_q       <= '0;
            cand_q       <= '0;
            best_idx_q   <= '0;
            best_score_q <= '0;
            valid_o      <= 1'b0;
            n_id_1_o     <= '0;
            n_id_o       <= '0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (peak_i) begin
                        // A sample arriving with the peak is already the first gap sample.
                        nid2_q    <= n_id_2_i;
                        gap_cnt_q <= valid_i ? GAP_W'(1) : '0;
                        state_q   <= GAP;
                    end
                end
                GAP: begin
                    if (valid_i) begin
                        if (gap_cnt_q == GAP_W'(`SSS_GAP - 1)) begin
                            smp_cnt_q <= '0;
                            state_q   <= COLLECT;
                        end else begin
                            gap_cnt_q <= gap_cnt_q + 1'b1;
                        end
                    end
                end
                COLLECT: begin
                    if (valid_i) begin
                        smp_cnt_q <= smp_cnt_q + 1'b1;
                        if (smp_cnt_q[0]) begin
                            chips_q[smp_cnt_q[CNT_W-1:1]] <= ~sample_i.re[$bits(rail_t)-1];
                        end
                        if (smp_cnt_q == CNT_W'(2 * `SSS_LEN - 1)) begin
                            cand_q       <= '0;
                            best_idx_q   <= '0;
                            best_score_q <= '0;
                            state_q      <= SEARCH;
                        end
                    end
                end
                SEARCH: begin
                    best_idx_q <= final_idx;
                    if (score > best_score_q) begin
                        best_score_q <= score;
                    end
                    cand_q <= cand_q + 1'b1;
                    if (cand_q == n_id_1_t'(`SSS_LEN - 1)) begin
                        valid_o  <= 1'b1;
                        n_id_1_o <= final_idx;
                        n_id_o   <= n_id_t'(final_idx) * n_id_t'(3) + n_id_t'(nid2_q);
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // A result closes a full search that started right after the last chip.
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        valid_o |-> $past(state_q == SEARCH) && $past(state_q == COLLECT, `SSS_LEN + 1))
        else $error("sss_detector: result valid outside the end of the search");

endmodule

// File: hdl/pss_correlator.sv
`timescale 1ns/1ps
`include "cell_search_consts.svh"

module pss_correlator import sample_pkg::*; import sync_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  logic       valid_i,
    output n_id_2_t    n_id_2_o,
    output logic       peak_o
);

    localparam int WIN    = 2 * `PSS_LEN;   // Two decimated samples per chip.
    localparam int HOLD_W = $clog2(`PSS_HOLDOFF + 1);
    localparam logic [`PSS_LEN-1:0] PSS_SEQ [3] = '{`PSS_SEQ_0, `PSS_SEQ_1, `PSS_SEQ_2};

    iq_sample_t        window_q [WIN];    // Index 0 holds the oldest sample.
    logic              valid_q;
    logic [HOLD_W-1:0] holdoff_q;
    corr_t             acc_re [3];
    corr_t             acc_im [3];
    metric_t           metric [3];
    metric_t           best_metric;
    n_id_2_t           best_idx;
    logic              fire;

    function automatic metric_t magnitude(input corr_t v);
        return (v < 0) ? metric_t'(-v) : metric_t'(v);
    endfunction

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            acc_re[s] = '0;
            acc_im[s] = '0;
            for (int k = 0; k < WIN; k++) begin
                if (PSS_SEQ[s][k/2]) begin
                    acc_re[s] = acc_re[s] + corr_t'(window_q[k].re);
                    acc_im[s] = acc_im[s] + corr_t'(window_q[k].im);
                end else begin
                    acc_re[s] = acc_re[s] - corr_t'(window_q[k].re);
                    acc_im[s] = acc_im[s] - corr_t'(window_q[k].im);
                end
            end
            metric[s] = magnitude(acc_re[s]) + magnitude(acc_im[s]);
        end
    end

    // On a tie the lower sequence index wins.
    always_comb begin
        best_metric = metric[0];
        best_idx    = '0;
        for (int s = 1; s < 3; s++) begin
            if (metric[s] > best_metric) begin
                best_metric = metric[s];
                best_idx    = n_id_2_t'(s);
            end
        end
    end

    assign fire = valid_q && (holdoff_q == '0) && (best_metric >= `PSS_THRESHOLD);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < WIN; k++) begin
                window_q[k] <= '0;   // Start from silence.
            end
            valid_q   <= 1'b0;
            holdoff_q <= '0;
            peak_o    <= 1'b0;
            n_id_2_o  <= '0;
        end else begin
            valid_q <= valid_i;
            peak_o  <= 1'b0;
            if (valid_i) begin
                for (int k = 0; k < WIN - 1; k++) begin
                    window_q[k] <= window_q[k+1];
                end
                window_q[WIN-1] <= sample_i;
            end
            if (fire) begin
                peak_o    <= 1'b1;
                n_id_2_o  <= best_idx;
                holdoff_q <= HOLD_W'(`PSS_HOLDOFF);
            end else if (valid_i && (holdoff_q != '0)) begin
                holdoff_q <= holdoff_q - 1'b1;   // Holdoff counts decimated samples.
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni) peak_o |-> (n_id_2_o < 2'd3))
        else $error("pss_correlator: peak with invalid N_id_2 %0d", n_id_2_o);

endmodule

// File: hdl/cic_decimator.sv
`timescale 1ns/1ps
`include "cell_search_consts.svh"

module cic_decimator import sample_pkg::*; #(
    parameter int DW = `IQ_DW
) (
    input  logic  clk_i,
    input  logic  reset_ni,
    input  rail_t data_i,
    input  logic  valid_i,
    output rail_t data_o,
    output logic  valid_o
);

    localparam int SHIFT = `CIC_N * $clog2(`CIC_R);   // Growth of N * log2(R * M) bits.
    localparam int AW    = DW + SHIFT;
    localparam int GAIN  = `CIC_R ** `CIC_N;

    logic signed [AW-1:0]      integ_q [`CIC_N];
    logic signed [AW-1:0]      integ_d [`CIC_N];
    logic signed [AW-1:0]      delay_q [`CIC_N];
    logic signed [AW-1:0]      comb_d  [`CIC_N];
    logic signed [AW-1:0]      rounded;
    logic [$clog2(`CIC_R)-1:0] phase_q;
    logic                      dump_q;

    // The integrator chain settles within the cycle, so the sum includes the current input.
    always_comb begin
        integ_d[0] = integ_q[0] + AW'(data_i);
        for (int i = 1; i < `CIC_N; i++) begin
            integ_d[i] = integ_q[i] + integ_d[i-1];
        end
    end

    always_comb begin
        comb_d[0] = integ_q[`CIC_N-1] - delay_q[0];
        for (int i = 1; i < `CIC_N; i++) begin
            comb_d[i] = comb_d[i-1] - delay_q[i];
        end
        // Divide by the gain, rounding toward zero.
        if (comb_d[`CIC_N-1] < 0) begin
            rounded = (comb_d[`CIC_N-1] + AW'(GAIN - 1)) >>> SHIFT;
        end else begin
            rounded = comb_d[`CIC_N-1] >>> SHIFT;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < `CIC_N; i++) begin
                integ_q[i] <= '0;
                delay_q[i] <= '0;
            end
            phase_q <= '0;
            dump_q  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            dump_q  <= valid_i && (phase_q == (`CIC_R - 1));
            valid_o <= dump_q;
            if (valid_i) begin
                integ_q <= integ_d;
                phase_q <= (phase_q == (`CIC_R - 1)) ? '0 : phase_q + 1'b1;
            end
            if (dump_q) begin
                delay_q[0] <= integ_q[`CIC_N-1];   // Differential delay of one output sample.
                for (int i = 1; i < `CIC_N; i++) begin
                    delay_q[i] <= comb_d[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dump_q) begin
            data_o <= rail_t'(rounded);
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni) valid_o |=> !valid_o)
        else $error("cic_decimator: output valid high on two consecutive cycles");

endmodule

// File: hdl/sync_pkg.sv
package sync_pkg;

    // Sector index from the primary sequence, 0 to 2.
    typedef logic [1:0] n_id_2_t;

    // Group index from the secondary sequence, 0 to 15 here.
    typedef logic [3:0] n_id_1_t;

    // Cell identity 3 * N_id_1 + N_id_2, at most 47.
    typedef logic [5:0] n_id_t;

endpackage

// File: hdl/sample_pkg.sv
`include "cell_search_consts.svh"

package sample_pkg;

    // One signed rail of the baseband stream.
    typedef logic signed [`IQ_DW-1:0] rail_t;

    // The imaginary half sits in the upper bits of a sample word.
    typedef struct packed {
        rail_t im;
        rail_t re;
    } iq_sample_t;

    // Signed sum over one correlation window.
    typedef logic signed [`CORR_DW-1:0] corr_t;

    // Magnitude |re| + |im| of a correlation, one bit wider than a sum.
    typedef logic [`CORR_DW:0] metric_t;

endpackage

// File: hdl/cell_search_consts.svh
`ifndef CELL_SEARCH_CONSTS_SVH
`define CELL_SEARCH_CONSTS_SVH

// One rail of a sample, and the width of the correlation sums.
`define IQ_DW         16
`define CORR_DW       22

`define CIC_R         2
`define CIC_N         3

// Chip i of a sequence is bit i of its word, a 1 bit is a chip of +1.
`define PSS_LEN       16
`define PSS_SEQ_0     16'h7591   // Length 15 m-sequence, shift 0, with a trailing -1 chip.
`define PSS_SEQ_1     16'h47AC   // Same m-sequence, shift 5.
`define PSS_SEQ_2     16'h323D   // Same m-sequence, shift 10.

// A clean aligned burst scores about 24 times the chip amplitude.
`define PSS_THRESHOLD 65536
`define PSS_HOLDOFF   64

`define SSS_GAP       8
`define SSS_LEN       16
`define SSS_BASE      16'h9AF1
`define SSS_SEED_0    16'h36C5
`define SSS_SEED_1    16'hA1E9
`define SSS_SEED_2    16'h5C1B

`endif
